// ==== flist.f ====
verilog/grid_pkg.sv
verilog/game_pkg.sv
verilog/tick_gen.sv
verilog/snake_mover.sv
verilog/food_gen.sv
verilog/game_ctrl.sv
verilog/snake_core.sv
test/snake_core_chk.sv
test/snake_core_tb.sv

// ==== test/snake_core_chk.sv ====
// ####################
// snake core checker
// step strobe and state transition assertions
// ####################
module snake_core_chk (
  input logic                  system_clk,
  input logic                  nreset,
  input logic                  step,
  input game_pkg::game_state_t state
);
  timeunit 1ns;
  timeprecision 100ps;

  // single-cycle strobe
  assert property (@(posedge system_clk) disable iff (!nreset) step |=> !step)
    else $error("step high two cycles in a row");

  // step only follows a running cycle
  assert property (@(posedge system_clk) disable iff (!nreset)
    step |-> ($past(state) == game_pkg::RUN))
    else $error("step without RUN state");

  // idle state only exits to run
  assert property (@(posedge system_clk) disable iff (!nreset)
    (state == game_pkg::WAIT) |=> (state inside {game_pkg::WAIT, game_pkg::RUN}))
    else $error("WAIT left to a state other than RUN");

  // quiet strobe on reset release
  assert property (@(posedge system_clk) $rose(nreset) |-> !step)
    else $error("step high after reset");

endmodule

bind snake_core snake_core_chk u_chk (
  .system_clk (system_clk),
  .nreset     (nreset),
  .step       (step),
  .state      (game_state)
);

// ==== test/snake_core_tb.sv ====
// ####################
// snake core testbench
// table-driven commands against a model of the game rules
// ####################
module snake_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {OP_NONE, OP_START, OP_PAUSE, OP_TURN, OP_SEEK} op_t;

  // steps is a budget on seek rows
  typedef struct packed {
    op_t                   op;
    grid_pkg::dir_t        dir;
    game_pkg::game_speed_t speed;
    logic [7:0]            steps;
  } row_t;

  localparam int n_rows = 11;
  localparam row_t rows [n_rows] = '{
    '{OP_NONE,  grid_pkg::RIGHT, game_pkg::NORMAL_SPEED, 8'd4},
    '{OP_START, grid_pkg::RIGHT, game_pkg::NORMAL_SPEED, 8'd2},
    '{OP_NONE,  grid_pkg::RIGHT, game_pkg::FAST_SPEED,   8'd2},
    '{OP_TURN,  grid_pkg::UP,    game_pkg::NORMAL_SPEED, 8'd2},
    '{OP_PAUSE, grid_pkg::RIGHT, game_pkg::NORMAL_SPEED, 8'd2},
    '{OP_PAUSE, grid_pkg::RIGHT, game_pkg::NORMAL_SPEED, 8'd1},
    '{OP_SEEK,  grid_pkg::RIGHT, game_pkg::NORMAL_SPEED, 8'd30},
    '{OP_NONE,  grid_pkg::RIGHT, game_pkg::SLOW_SPEED,   8'd2},
    '{OP_TURN,  grid_pkg::DOWN,  game_pkg::NORMAL_SPEED, 8'd1},
    '{OP_NONE,  grid_pkg::RIGHT, game_pkg::NORMAL_SPEED, 8'd3},
    '{OP_START, grid_pkg::RIGHT, game_pkg::NORMAL_SPEED, 8'd2}
  };

  logic                   system_clk;
  logic                   nreset;
  game_pkg::game_cmd_t    cmd;
  game_pkg::game_speed_t  speed;
  game_pkg::game_status_t status;
  logic                   step;

  // reference model
  game_pkg::game_state_t m_state;
  logic [7:0]            m_score;
  grid_pkg::pos_t        m_head;
  grid_pkg::pos_t        m_food;
  grid_pkg::dir_t        m_cur;
  grid_pkg::dir_t        m_pend;
  int                    m_len;
  logic                  m_grow;
  logic                  m_ate;
  // step timing
  int                    cyc;
  int                    last_step_cyc;
  int                    cur_period;
  int                    errors;

  snake_core u_dut (
    .system_clk (system_clk),
    .nreset     (nreset),
    .cmd        (cmd),
    .speed      (speed),
    .status     (status),
    .step       (step)
  );

  initial begin
    system_clk = 1'b0;
    forever #2 system_clk = ~system_clk;
  end

  always @(posedge system_clk) cyc <= cyc + 1;

  // terminal counts per speed, unused code runs normal
  function automatic int period_of(game_pkg::game_speed_t s);
    case (s)
      game_pkg::FAST_SPEED: return 20;
      game_pkg::SLOW_SPEED: return 30;
      default:              return 25;
    endcase
  endfunction

  function automatic grid_pkg::dir_t opposite(grid_pkg::dir_t d);
    case (d)
      grid_pkg::RIGHT: return grid_pkg::LEFT;
      grid_pkg::LEFT:  return grid_pkg::RIGHT;
      grid_pkg::UP:    return grid_pkg::DOWN;
      default:         return grid_pkg::UP;
    endcase
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one move of the model head
  task automatic model_step();
    int x;
    int y;
    x = m_head.x;
    y = m_head.y;
    case (m_pend)
      grid_pkg::RIGHT: x++;
      grid_pkg::LEFT:  x--;
      grid_pkg::UP:    y--;
      default:         y++;
    endcase
    m_ate = 1'b0;
    m_cur = m_pend;
    if (x < 0 || x > 15 || y < 0 || y > 15) begin
      // wall, head stays put
      m_state = game_pkg::END_GAME;
    end else begin
      if (m_grow && m_len < 8) m_len++;
      m_grow   = 1'b0;
      m_head.x = grid_pkg::coord_t'(x);
      m_head.y = grid_pkg::coord_t'(y);
      if (m_head == m_food) begin
        if (m_score != 8'hff) m_score++;
        m_grow = 1'b1;
        m_ate  = 1'b1;
      end
    end
  endtask

  // no step and a frozen head
  task automatic stay_idle(input int cycles);
    repeat (cycles) begin
      @(negedge system_clk);
      check(step, 1'b0, "step while not running");
      check(status.head, m_head, "head moved while not running");
    end
  endtask

  task automatic take_step();
    int             waited;
    grid_pkg::pos_t old_food;
    waited = 0;
    @(negedge system_clk);
    while (!step && waited < 64) begin
      @(negedge system_clk);
      waited++;
    end
    if (!step) begin
      $display("no step pulse arrived within 64 cycles at %0t ns", $time);
      $display("Errors found");
      $fatal(1, "missing step");
    end
    check(cyc - last_step_cyc, cur_period + 1, "step spacing");
    last_step_cyc = cyc;
    // the wrap just taken latched the current speed
    cur_period = period_of(speed);
    old_food   = m_food;
    model_step();
    @(negedge system_clk);
    check(status.head, m_head, "head after step");
    @(negedge system_clk);
    check(status.state, m_state, "state after step");
    check(status.score, m_score, "score after step");
    @(negedge system_clk);
    if (m_ate) begin
      check(status.food != old_food, 1'b1, "food kept its cell after eat");
      m_food = status.food;
    end
  endtask

  task automatic run_steps(input int n);
    repeat (n) begin
      if (m_state == game_pkg::RUN) take_step();
      else stay_idle(cur_period + 1);
    end
  endtask

  task automatic apply_cmd(input op_t op, input grid_pkg::dir_t d,
                           input game_pkg::game_speed_t s);
    int c0;
    @(negedge system_clk);
    speed         = s;
    cmd.start     = (op == OP_START);
    cmd.pause     = (op == OP_PAUSE);
    cmd.dir_valid = (op == OP_TURN);
    cmd.dir       = d;
    c0            = cyc;
    case (op)
      OP_START: begin
        if (m_state == game_pkg::WAIT || m_state == game_pkg::END_GAME) begin
          if (m_state == game_pkg::END_GAME) begin
            // new round, mover and food reload
            m_score = '0;
            m_head  = grid_pkg::start_pos;
            m_food  = grid_pkg::food_start_pos;
            m_cur   = grid_pkg::RIGHT;
            m_pend  = grid_pkg::RIGHT;
            m_len   = 1;
            m_grow  = 1'b0;
          end
          m_state       = game_pkg::RUN;
          last_step_cyc = c0 + 1;
          cur_period    = period_of(s);
        end
      end
      OP_PAUSE: begin
        if (m_state == game_pkg::RUN) begin
          m_state = game_pkg::PAUSE;
        end else if (m_state == game_pkg::PAUSE) begin
          m_state       = game_pkg::RUN;
          last_step_cyc = c0 + 1;
          cur_period    = period_of(s);
        end
      end
      OP_TURN: begin
        // reversal ignored once the body is longer than the head
        if (!(d == opposite(m_cur) && m_len > 1)) m_pend = d;
      end
      default: ;
    endcase
    @(negedge system_clk);
    cmd = '0;
    @(negedge system_clk);
    check(status.state, m_state, "state after command");
    check(status.score, m_score, "score after command");
    check(status.head, m_head, "head after command");
    check(status.food, m_food, "food after command");
  endtask

  // x leg first, then y leg, toward the observed food
  task automatic seek_food(input game_pkg::game_speed_t s);
    grid_pkg::pos_t target;
    logic [7:0]     score_before;
    int             dx;
    int             dy;
    target       = status.food;
    score_before = m_score;
    check(target, m_food, "food before seek");
    dx = int'(target.x) - int'(m_head.x);
    dy = int'(target.y) - int'(m_head.y);
    if (dx != 0) begin
      apply_cmd(OP_TURN, (dx > 0) ? grid_pkg::RIGHT : grid_pkg::LEFT, s);
      run_steps((dx > 0) ? dx : -dx);
    end
    if (dy != 0) begin
      apply_cmd(OP_TURN, (dy > 0) ? grid_pkg::DOWN : grid_pkg::UP, s);
      run_steps((dy > 0) ? dy : -dy);
    end
    check(status.score, score_before + 8'd1, "score after reaching the food");
  endtask

  initial begin
    cmd           = '0;
    speed         = game_pkg::NORMAL_SPEED;
    nreset        = 1'b0;
    cyc           = 0;
    errors        = 0;
    m_state       = game_pkg::WAIT;
    m_score       = '0;
    m_head        = grid_pkg::start_pos;
    m_food        = grid_pkg::food_start_pos;
    m_cur         = grid_pkg::RIGHT;
    m_pend        = grid_pkg::RIGHT;
    m_len         = 1;
    m_grow        = 1'b0;
    m_ate         = 1'b0;
    last_step_cyc = 0;
    cur_period    = 25;
    repeat (3) @(posedge system_clk);
    @(negedge system_clk);
    nreset = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      if (rows[i].op == OP_SEEK) begin
        seek_food(rows[i].speed);
      end else begin
        apply_cmd(rows[i].op, rows[i].dir, rows[i].speed);
        run_steps(rows[i].steps);
      end
    end
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // slowest step spacing for every table step, plus margin
  initial begin
    int total;
    total = 0;
    foreach (rows[i]) total += rows[i].steps;
    #(total * 31 * 4 + 200);
    $display("timeout, the run did not finish within %0d ns", total * 31 * 4 + 200);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== verilog/food_gen.sv ====
// ####################
// food generator
// lfsr picks a new food cell on every eat
// ####################
module food_gen (
  input  logic           system_clk,
  input  logic           nreset,
  input  logic           eat,
  input  logic           restart,
  input  grid_pkg::pos_t head,
  output grid_pkg::pos_t food
);

  logic [15:0]    lfsr;
  logic           feedback;
  grid_pkg::pos_t candidate;

  // taps 16 14 13 11, maximal length
  assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  // low byte as the cell, x flipped off the head
  always_comb begin
    candidate = grid_pkg::pos_t'(lfsr[7:0]);
    if (candidate == head) begin
      candidate.x = ~candidate.x;
    end
  end

  // free running every cycle
  always_ff @(posedge system_clk, negedge nreset) begin
    if (!nreset) begin
      lfsr <= grid_pkg::lfsr_seed;
    end else begin
      lfsr <= {lfsr[14:0], feedback};
    end
  end

  always_ff @(posedge system_clk, negedge nreset) begin
    if (!nreset) begin
      food <= grid_pkg::food_start_pos;
    end else if (restart) begin
      food <= grid_pkg::food_start_pos;
    end else if (eat) begin
      food <= candidate;
    end
  end

endmodule

// ==== verilog/game_ctrl.sv ====
// ####################
// game control
// state machine, score, eat and end-of-game decisions
// ####################
module game_ctrl (
  input  logic                   system_clk,
  input  logic                   nreset,
  input  game_pkg::game_cmd_t    cmd,
  input  grid_pkg::move_result_t move_result,
  input  grid_pkg::pos_t         food,
  output game_pkg::game_state_t  game_state,
  output logic                   grow,
  output logic                   eat,
  output logic                   restart,
  output game_pkg::game_status_t status
);

  logic [game_pkg::score_w-1:0] score;
  logic                         hit;
  logic                         eat_hit;
  logic                         score_max;

  // collision on the step just taken
  assign hit = move_result.moved & (move_result.wall_hit | move_result.self_hit);

  // clean step landing on the food
  assign eat_hit = move_result.moved & ~hit & (move_result.head == food);

  assign score_max = (score == '1);

  always_ff @(posedge system_clk, negedge nreset) begin
    if (!nreset) begin
      game_state <= game_pkg::WAIT;
      score      <= '0;
      grow       <= 1'b0;
      eat        <= 1'b0;
      restart    <= 1'b0;
    end else begin
      // strobes default low
      grow    <= 1'b0;
      eat     <= 1'b0;
      restart <= 1'b0;
      if (hit) begin
        // collision beats any command in the same cycle
        game_state <= game_pkg::END_GAME;
      end else begin
        if (eat_hit) begin
          eat  <= 1'b1;
          grow <= 1'b1;
          // saturate at 255
          if (!score_max) begin
            score <= score + game_pkg::score_w'(1);
          end
        end
        case (game_state)
          game_pkg::WAIT: begin
            if (cmd.start) game_state <= game_pkg::RUN;
          end
          game_pkg::END_GAME: begin
            // new round, mover and food reload
            if (cmd.start) begin
              game_state <= game_pkg::RUN;
              restart    <= 1'b1;
              score      <= '0;
            end
          end
          game_pkg::RUN: begin
            if (cmd.pause) game_state <= game_pkg::PAUSE;
          end
          default: begin
            if (cmd.pause) game_state <= game_pkg::RUN;
          end
        endcase
      end
    end
  end

  assign status = '{state: game_state, score: score, head: move_result.head, food: food};

endmodule

// ==== verilog/game_pkg.sv ====
// ####################
// game package
// game states, speeds, command and status words
// ####################
package game_pkg;

  typedef enum logic [1:0] {
    RUN      = 2'b00,
    WAIT     = 2'b01,
    PAUSE    = 2'b10,
    END_GAME = 2'b11
  } game_state_t;

  // code 2'b11 is unused, treated as normal
  typedef enum logic [1:0] {
    NORMAL_SPEED = 2'b00,
    FAST_SPEED   = 2'b01,
    SLOW_SPEED   = 2'b10
  } game_speed_t;

  // step counter width and terminal counts
  // simulation scale, a board build only changes these
  localparam int count_w = 6;
  localparam logic [count_w-1:0] step_period_normal = count_w'(25);
  localparam logic [count_w-1:0] step_period_fast   = count_w'(20);
  localparam logic [count_w-1:0] step_period_slow   = count_w'(30);

  localparam int score_w = 8;

  // button strobes plus steering
  typedef struct packed {
    logic          start;
    logic          pause;
    logic          dir_valid;
    grid_pkg::dir_t dir;
  } game_cmd_t;

  typedef struct packed {
    game_state_t        state;
    logic [score_w-1:0] score;
    grid_pkg::pos_t     head;
    grid_pkg::pos_t     food;
  } game_status_t;

endpackage

// ==== verilog/grid_pkg.sv ====
// ####################
// grid package
// board size, cell coordinates, directions and snake limits
// ####################
package grid_pkg;

  // 16 by 16 board
  localparam int grid_w = 4;

  typedef logic [grid_w-1:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } pos_t;

  // up moves toward row 0
  // opposite directions differ only in bit 0
  typedef enum logic [1:0] {
    RIGHT = 2'b00,
    LEFT  = 2'b01,
    UP    = 2'b10,
    DOWN  = 2'b11
  } dir_t;

  // head cell after reset or restart
  localparam pos_t start_pos = '{x: coord_t'(8), y: coord_t'(8)};

  // food cell after reset or restart
  localparam pos_t food_start_pos = '{x: coord_t'(3), y: coord_t'(3)};

  // food lfsr seed, any nonzero value
  localparam logic [15:0] lfsr_seed = 16'hace1;

  // longest body the mover can hold
  localparam int max_len = 8;

  typedef logic [3:0] len_t;

  // one step outcome from the mover
  typedef struct packed {
    logic moved;
    logic wall_hit;
    logic self_hit;
    pos_t head;
  } move_result_t;

endpackage

// ==== verilog/snake_core.sv ====
// ####################
// snake core top
// step generator, mover, food and control
// ####################
module snake_core (
  input  logic                   system_clk,
  input  logic                   nreset,
  input  game_pkg::game_cmd_t    cmd,
  input  game_pkg::game_speed_t  speed,
  output game_pkg::game_status_t status,
  output logic                   step
);

  game_pkg::game_state_t  game_state;
  grid_pkg::move_result_t move_result;
  grid_pkg::pos_t         food;
  logic                   grow;
  logic                   eat;
  logic                   restart;

  tick_gen u_tick_gen (
    .system_clk (system_clk),
    .nreset     (nreset),
    .game_state (game_state),
    .game_speed (speed),
    .step       (step)
  );

  // steering goes straight to the mover
  snake_mover u_snake_mover (
    .system_clk  (system_clk),
    .nreset      (nreset),
    .step        (step),
    .dir_valid   (cmd.dir_valid),
    .dir         (cmd.dir),
    .grow        (grow),
    .restart     (restart),
    .move_result (move_result)
  );

  food_gen u_food_gen (
    .system_clk (system_clk),
    .nreset     (nreset),
    .eat        (eat),
    .restart    (restart),
    .head       (move_result.head),
    .food       (food)
  );

  game_ctrl u_game_ctrl (
    .system_clk  (system_clk),
    .nreset      (nreset),
    .cmd         (cmd),
    .move_result (move_result),
    .food        (food),
    .game_state  (game_state),
    .grow        (grow),
    .eat         (eat),
    .restart     (restart),
    .status      (status)
  );

endmodule

// ==== verilog/snake_mover.sv ====
// ####################
// snake mover
// head and body shift register, steering, wall and self collisions
// ####################
module snake_mover (
  input  logic                   system_clk,
  input  logic                   nreset,
  input  logic                   step,
  input  logic                   dir_valid,
  input  grid_pkg::dir_t         dir,
  input  logic                   grow,
  input  logic                   restart,
  output grid_pkg::move_result_t move_result
);

  grid_pkg::pos_t head;
  grid_pkg::pos_t next_head;
  // cells behind the head, tail[0] is the neck
  grid_pkg::pos_t tail [grid_pkg::max_len-1];
  grid_pkg::len_t len;
  grid_pkg::len_t occupied;
  grid_pkg::dir_t cur_dir;
  grid_pkg::dir_t pend_dir;
  logic           grow_pending;
  logic           wall;
  logic           self_hit;
  logic           reverse;
  logic           moved_q;
  logic           wall_q;
  logic           self_q;

  // reversal means flipping bit 0 of the last moved direction
  assign reverse = (dir == grid_pkg::dir_t'({cur_dir[1], ~cur_dir[0]}));

  // candidate head one cell along the pending direction
  always_comb begin
    next_head = head;
    wall      = 1'b0;
    case (pend_dir)
      grid_pkg::RIGHT: begin
        if (head.x == '1) wall = 1'b1;
        else next_head.x = head.x + grid_pkg::coord_t'(1);
      end
      grid_pkg::LEFT: begin
        if (head.x == '0) wall = 1'b1;
        else next_head.x = head.x - grid_pkg::coord_t'(1);
      end
      grid_pkg::UP: begin
        if (head.y == '0) wall = 1'b1;
        else next_head.y = head.y - grid_pkg::coord_t'(1);
      end
      default: begin
        if (head.y == '1) wall = 1'b1;
        else next_head.y = head.y + grid_pkg::coord_t'(1);
      end
    endcase
  end

  // tail end vacates on a plain step, stays when growing
  assign occupied = (grow_pending && (len < grid_pkg::len_t'(grid_pkg::max_len))) ?
                    len : len - grid_pkg::len_t'(1);

  always_comb begin
    self_hit = 1'b0;
    for (int i = 0; i < grid_pkg::max_len - 1; i++) begin
      // tail[i] is body cell i+1
      if ((grid_pkg::len_t'(i + 1) < occupied) && (tail[i] == next_head)) begin
        self_hit = 1'b1;
      end
    end
  end

  always_ff @(posedge system_clk, negedge nreset) begin
    if (!nreset) begin
      head         <= grid_pkg::start_pos;
      len          <= grid_pkg::len_t'(1);
      cur_dir      <= grid_pkg::RIGHT;
      pend_dir     <= grid_pkg::RIGHT;
      grow_pending <= 1'b0;
      moved_q      <= 1'b0;
      wall_q       <= 1'b0;
      self_q       <= 1'b0;
    end else if (restart) begin
      head         <= grid_pkg::start_pos;
      len          <= grid_pkg::len_t'(1);
      cur_dir      <= grid_pkg::RIGHT;
      pend_dir     <= grid_pkg::RIGHT;
      grow_pending <= 1'b0;
      moved_q      <= 1'b0;
      wall_q       <= 1'b0;
      self_q       <= 1'b0;
    end else begin
      moved_q <= step;
      wall_q  <= step & wall;
      self_q  <= step & ~wall & self_hit;
      // single cell snake may turn around freely
      if (dir_valid && !(reverse && (len > grid_pkg::len_t'(1)))) begin
        pend_dir <= dir;
      end
      // a fresh grow strobe wins over the step that clears it
      grow_pending <= grow | (grow_pending & ~step);
      if (step) begin
        cur_dir <= pend_dir;
        if (!wall && !self_hit) begin
          head <= next_head;
          if (grow_pending && (len < grid_pkg::len_t'(grid_pkg::max_len))) begin
            len <= len + grid_pkg::len_t'(1);
          end
        end
      end
    end
  end

  // body shift, only cells below len are ever compared
  always_ff @(posedge system_clk) begin
    if (step && !wall && !self_hit) begin
      tail[0] <= head;
      for (int i = 1; i < grid_pkg::max_len - 1; i++) begin
        tail[i] <= tail[i-1];
      end
    end
  end

  assign move_result = '{moved: moved_q, wall_hit: wall_q, self_hit: self_q, head: head};

endmodule

// ==== verilog/tick_gen.sv ====
// ####################
// step generator
// one-cycle movement strobe per speed period while running
// ####################
module tick_gen (
  input  logic                  system_clk,
  input  logic                  nreset,
  input  game_pkg::game_state_t game_state,
  input  game_pkg::game_speed_t game_speed,
  output logic                  step
);

  logic [game_pkg::count_w-1:0] counter;
  logic [game_pkg::count_w-1:0] period;
  logic [game_pkg::count_w-1:0] speed_period;
  logic                         running;
  logic                         wrap;

  assign running = (game_state == game_pkg::RUN);
  assign wrap    = (counter == period);

  // terminal count for the requested speed
  always_comb begin
    case (game_speed)
      game_pkg::FAST_SPEED: speed_period = game_pkg::step_period_fast;
      game_pkg::SLOW_SPEED: speed_period = game_pkg::step_period_slow;
      default:              speed_period = game_pkg::step_period_normal;
    endcase
  end

  // period only reloads at a wrap, so speed changes wait a full period
  always_ff @(posedge system_clk, negedge nreset) begin
    if (!nreset) begin
      counter <= '0;
      period  <= game_pkg::step_period_normal;
      step    <= 1'b0;
    end else if (!running) begin
      // held idle, resume starts a full period
      counter <= '0;
      period  <= speed_period;
      step    <= 1'b0;
    end else if (wrap) begin
      counter <= '0;
      period  <= speed_period;
      step    <= 1'b1;
    end else begin
      counter <= counter + game_pkg::count_w'(1);
      step    <= 1'b0;
    end
  end

endmodule
